/* wiscCfg.svh */
`ifndef WISC_CFG_SVH
`define WISC_CFG_SVH

// Datapath sizing for the 16-bit teaching core.
`define WISC_DW   16 // Data and PC width.
`define WISC_NREG 8  // Architectural registers.
`define WISC_RW   3  // Register index width.
`define WISC_OPW  5  // Opcode field, instr[15:11].

`endif

/* wiscPkg.sv */
`include "wiscCfg.svh"

package wiscPkg;

   typedef logic [`WISC_DW-1:0] dataT; // Data and PC word.

   // Opcodes of the supported subset.
   typedef enum logic [`WISC_OPW-1:0] {
      opJr    = 5'b00101, // PC <- Rs + sext(imm8).
      opAddi  = 5'b01000,
      opSubi  = 5'b01001, // Rd <- imm - Rs.
      opXori  = 5'b01010,
      opAndni = 5'b01011,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opBltz  = 5'b01110,
      opBgez  = 5'b01111,
      opSlbi  = 5'b10010,
      opRoli  = 5'b10100,
      opSlli  = 5'b10101,
      opRori  = 5'b10110,
      opSrli  = 5'b10111,
      opLbi   = 5'b11000,
      opShift = 5'b11010, // R-format rol/sll/ror/srl.
      opAlu   = 5'b11011, // R-format add/sub/xor/andn.
      opSeq   = 5'b11100,
      opSlt   = 5'b11101,
      opSle   = 5'b11110,
      opSco   = 5'b11111
   } opcodeT;

   // Shifts occupy the low half so the funct bits map straight in.
   typedef enum logic [2:0] {
      aluRol, aluSll, aluRor, aluSrl, aluAdd, aluAnd, aluOr, aluXor
   } aluOpT;

   typedef enum logic [1:0] {bReg, bImm5, bImm8, bSlbi} bSrcT; // B operand source.

   // Top bit flags a branch, low bits pick the condition.
   typedef enum logic [2:0] {
      brNone = 3'b000,
      brEqz  = 3'b100,
      brNez  = 3'b101,
      brLtz  = 3'b110,
      brGez  = 3'b111
   } brTypeT;

endpackage

/* cla_16b.sv */
`timescale 1ns/1ps

module cla_16b #(
   parameter int N = 16 // Must be a multiple of 4.
) (
   input  logic [N-1:0] a,
   input  logic [N-1:0] b,
   input  logic         cIn,
   output logic [N-1:0] sum,
   output logic         cOut
);

   logic [N-1:0] g;   // Bit generate.
   logic [N-1:0] p;   // Bit propagate.
   logic [N/4:0] grpC; // Carry into each group, ripple between groups.

   assign g       = a & b;
   assign p       = a ^ b;
   assign grpC[0] = cIn;

   for (genvar i = 0; i < N/4; i++) begin : gGroup
      logic [3:0] gi;
      logic [3:0] pi;
      logic [3:0] c;  // Carry into each bit of the group.
      logic       grpG;
      logic       grpP;

      assign gi   = g[4*i +: 4];
      assign pi   = p[4*i +: 4];
      assign c[0] = grpC[i];
      assign c[1] = gi[0] | (pi[0] & grpC[i]);
      assign c[2] = gi[1] | (pi[1] & gi[0]) | (pi[1] & pi[0] & grpC[i]);
      assign c[3] = gi[2] | (pi[2] & gi[1]) | (pi[2] & pi[1] & gi[0])
                  | (pi[2] & pi[1] & pi[0] & grpC[i]);

      // Group terms for the next group's carry.
      assign grpG = gi[3] | (pi[3] & gi[2]) | (pi[3] & pi[2] & gi[1])
                  | (pi[3] & pi[2] & pi[1] & gi[0]);
      assign grpP = &pi;

      assign grpC[i+1]    = grpG | (grpP & grpC[i]);
      assign sum[4*i +: 4] = pi ^ c; // Sum bits of this group.
   end

   assign cOut = grpC[N/4];

endmodule

/* alu.sv */
`timescale 1ns/1ps
`include "wiscCfg.svh"

module alu (
   input  wiscPkg::dataT  inA,
   input  wiscPkg::dataT  inB,
   input  logic           cin,
   input  wiscPkg::aluOpT oper,
   input  logic           invA,
   input  logic           invB,
   input  logic           sign,
   output wiscPkg::dataT  out,
   output logic           zero,
   output logic           ofl
);

   import wiscPkg::*;

   localparam int Msb = `WISC_DW - 1;

   dataT                   aa;    // A after optional inversion.
   dataT                   bb;    // B after optional inversion.
   dataT                   sum;   // Adder result.
   logic                   cOut;  // Adder carry out.
   logic [3:0]             shAmt; // Shift count from B.
   logic [2*`WISC_DW-1:0]  rolW;  // Doubled word shifted left.
   logic [2*`WISC_DW-1:0]  rorW;  // Doubled word shifted right.

   assign aa    = invA ? ~inA : inA;
   assign bb    = invB ? ~inB : inB;
   assign shAmt = bb[3:0];
   assign rolW  = {aa, aa} << shAmt; // Upper half is the rotated word.
   assign rorW  = {aa, aa} >> shAmt; // Lower half is the rotated word.

   cla_16b #(.N(`WISC_DW)) adder (
      .a    (aa),
      .b    (bb),
      .cIn  (cin),
      .sum  (sum),
      .cOut (cOut)
   );

   ////////////////////////////////////////
   // Result select.
   ////////////////////////////////////////
   always_comb begin
      case (oper)
         aluRol:  out = rolW[2*`WISC_DW-1:`WISC_DW];
         aluSll:  out = aa << shAmt;
         aluRor:  out = rorW[`WISC_DW-1:0];
         aluSrl:  out = aa >> shAmt;   // Logical shift with zero fill.
         aluAdd:  out = sum;
         aluAnd:  out = aa & bb;
         aluOr:   out = aa | bb;
         default: out = aa ^ bb;
      endcase
   end

   assign zero = (out == '0);
   // Signed overflow when like-signed operands give a differently signed sum.
   assign ofl  = sign ? ((aa[Msb] == bb[Msb]) && (sum[Msb] != aa[Msb])) : cOut;

   // Lookahead adder agrees with a plain sum.
   always_comb begin
      assert final ($isunknown({aa, bb, cin})
                    || ({cOut, sum} == ({1'b0, aa} + {1'b0, bb} + cin)))
         else $error("alu adder disagrees with the expected sum");
   end

endmodule

/* execute.sv */
`timescale 1ns/1ps
`include "wiscCfg.svh"

module execute (
   input  wiscPkg::opcodeT opcode,
   input  wiscPkg::dataT   pc,      // Already incremented.
   input  wiscPkg::aluOpT  oper,
   input  wiscPkg::dataT   a,
   input  wiscPkg::dataT   regData,
   input  wiscPkg::dataT   inst4,
   input  wiscPkg::dataT   inst7,
   input  wiscPkg::dataT   inst10,
   input  wiscPkg::dataT   slbi,
   input  wiscPkg::bSrcT   bSrc,
   input  logic            invA,
   input  logic            invB,
   input  logic            cin,
   input  logic            sign,
   input  logic            immSrc,  // Picks inst10 for the branch offset.
   input  logic            aluJump,
   input  wiscPkg::brTypeT brType,
   output wiscPkg::dataT   xcomp,
   output wiscPkg::dataT   newPc,
   output wiscPkg::dataT   bInput
);

   import wiscPkg::*;

   dataT aluRes;  // Raw ALU result.
   dataT brImm;   // Offset into the target adder.
   dataT target;  // PC plus offset.
   logic zf;      // Zero flag.
   logic sf;      // Sign flag.
   logic of;      // Overflow or carry, per sign.
   logic takeBr;  // Branch condition met.

   ////////////////////////////////////////
   // B operand select.
   ////////////////////////////////////////
   always_comb begin
      if (brType[2]) begin
         bInput = '0; // Branches test Rs alone.
      end else begin
         case (bSrc)
            bReg:    bInput = regData;
            bImm5:   bInput = inst4;
            bImm8:   bInput = inst7;
            default: bInput = slbi;
         endcase
      end
   end

   alu exAlu (
      .inA  (a),
      .inB  (bInput),
      .cin  (cin),
      .oper (oper),
      .invA (invA),
      .invB (invB),
      .sign (sign),
      .out  (aluRes),
      .zero (zf),
      .ofl  (of)
   );

   assign sf = aluRes[`WISC_DW-1];

   // Set-on-condition results are 0 or 1.
   always_comb begin
      case (opcode)
         opSeq:   xcomp = dataT'(zf);
         opSlt:   xcomp = dataT'(sf ^ of);        // Overflow flips the sign.
         opSle:   xcomp = dataT'((sf ^ of) | zf);
         opSco:   xcomp = dataT'(of);             // Carry out of Rs + Rt.
         default: xcomp = aluRes;
      endcase
   end

   ////////////////////////////////////////
   // Branch decision and target.
   ////////////////////////////////////////
   always_comb begin
      case (brType)
         brEqz:   takeBr = zf;
         brNez:   takeBr = ~zf;
         brLtz:   takeBr = sf;
         brGez:   takeBr = ~sf | zf;
         default: takeBr = 1'b0;
      endcase
   end

   assign brImm = immSrc ? inst10 : inst7;

   cla_16b #(.N(`WISC_DW)) pcAdder (
      .a    (pc),
      .b    (brImm),
      .cIn  (1'b0),
      .sum  (target),
      .cOut ()
   );

   assign newPc = aluJump ? aluRes : (takeBr ? target : pc);

   // Decode never marks one instruction as both jump and branch.
   always_comb begin
      assert final ($isunknown({aluJump, brType}) || !(aluJump && brType[2]))
         else $error("execute sees jr and a branch at once");
   end

endmodule

/* decode.sv */
`timescale 1ns/1ps
`include "wiscCfg.svh"

module decode (
   input  logic                  clk,
   input  logic                  rstN,
   input  wiscPkg::dataT         instr,
   input  wiscPkg::dataT         pcIn,
   input  logic                  instrValid,
   output logic [`WISC_RW-1:0]   rdAddr1,
   output logic [`WISC_RW-1:0]   rdAddr2,
   input  wiscPkg::dataT         rdData1,
   input  wiscPkg::dataT         rdData2,
   output logic                  exValid,
   output wiscPkg::opcodeT       exOpcode,
   output wiscPkg::aluOpT        exOper,
   output wiscPkg::bSrcT         exBSrc,
   output logic                  exInvA,
   output logic                  exInvB,
   output logic                  exCin,
   output logic                  exSign,
   output logic                  exImmSrc,
   output logic                  exAluJump,
   output wiscPkg::brTypeT       exBrType,
   output logic                  exWrEn,
   output logic [`WISC_RW-1:0]   exDst,
   output wiscPkg::dataT         exA,
   output wiscPkg::dataT         exRegData,
   output wiscPkg::dataT         exInst4,
   output wiscPkg::dataT         exInst7,
   output wiscPkg::dataT         exInst10,
   output wiscPkg::dataT         exSlbi,
   output wiscPkg::dataT         exPc
);

   import wiscPkg::*;

   opcodeT              opc;
   aluOpT               oper;
   bSrcT                bSrc;
   brTypeT              brType;
   logic                invA, invB, cin, sign;
   logic                immSrc;
   logic                zExt;    // Zero-extend the 5-bit immediate.
   logic                zeroA;   // Force A to zero for lbi and slbi.
   logic                aluJump;
   logic                wr;
   logic [`WISC_RW-1:0] dst;

   assign opc     = opcodeT'(instr[15:11]);
   assign rdAddr1 = instr[10:8]; // Rs.
   assign rdAddr2 = instr[7:5];  // Rt.

   ////////////////////////////////////////
   // Control decode.
   ////////////////////////////////////////
   always_comb begin
      oper    = aluAdd;
      bSrc    = bReg;
      brType  = brNone;
      invA    = 1'b0;
      invB    = 1'b0;
      cin     = 1'b0;
      sign    = 1'b0;
      immSrc  = 1'b0;        // No J-format here, branches use imm8.
      zExt    = 1'b0;
      zeroA   = 1'b0;
      aluJump = 1'b0;
      wr      = 1'b1;
      dst     = instr[7:5];  // I-format Rd.
      case (opc)
         opAddi, opSubi, opXori, opAndni: begin
            bSrc = bImm5;
            zExt = opc[1];                 // xori, andni.
            invA = (opc == opSubi);        // imm - Rs.
            cin  = (opc == opSubi);
            invB = (opc == opAndni);
            oper = opc[1] ? (opc[0] ? aluAnd : aluXor) : aluAdd;
         end
         opRoli, opSlli, opRori, opSrli: begin
            bSrc = bImm5;
            zExt = 1'b1;
            oper = aluOpT'({1'b0, instr[12:11]});
         end
         opLbi, opSlbi: begin
            bSrc  = (opc == opSlbi) ? bSlbi : bImm8;
            zeroA = 1'b1;                  // ALU passes B through.
            oper  = aluOr;
            dst   = instr[10:8];
         end
         opAlu: begin
            dst  = instr[4:2];
            invA = (instr[1:0] == 2'b01);  // sub is Rt - Rs.
            cin  = (instr[1:0] == 2'b01);
            invB = (instr[1:0] == 2'b11);  // andn.
            oper = instr[1] ? (instr[0] ? aluAnd : aluXor) : aluAdd;
         end
         opShift: begin
            dst  = instr[4:2];
            oper = aluOpT'({1'b0, instr[1:0]});
         end
         opSeq, opSlt, opSle, opSco: begin
            dst  = instr[4:2];
            invB = (opc != opSco);         // Compares take Rs - Rt.
            cin  = (opc != opSco);
            sign = (opc != opSco);         // sco wants the carry.
         end
         opBeqz, opBnez, opBltz, opBgez: begin
            brType = brTypeT'({1'b1, instr[12:11]});
            wr     = 1'b0;
         end
         opJr: begin
            bSrc    = bImm8;
            aluJump = 1'b1;
            wr      = 1'b0;
         end
         default: wr = 1'b0; // Unknown opcode retires without a write.
      endcase
   end

   ////////////////////////////////////////
   // Decode/execute register.
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rstN) begin
         exValid   <= 1'b0;
         exWrEn    <= 1'b0;
         exAluJump <= 1'b0;
         exBrType  <= brNone;
      end else begin
         exValid   <= instrValid;
         exWrEn    <= instrValid & wr;
         exAluJump <= instrValid & aluJump;
         exBrType  <= instrValid ? brType : brNone; // Bubbles never branch.
      end
   end

   always_ff @(posedge clk) begin
      exOpcode  <= opc;
      exOper    <= oper;
      exBSrc    <= bSrc;
      exInvA    <= invA;
      exInvB    <= invB;
      exCin     <= cin;
      exSign    <= sign;
      exImmSrc  <= immSrc;
      exDst     <= dst;
      exA       <= zeroA ? '0 : rdData1;
      exRegData <= rdData2;
      exInst4   <= {{(`WISC_DW-5){~zExt & instr[4]}}, instr[4:0]};
      exInst7   <= {{(`WISC_DW-8){instr[7]}}, instr[7:0]};
      exInst10  <= {{(`WISC_DW-11){instr[10]}}, instr[10:0]};
      exSlbi    <= (rdData1 << 8) | dataT'(instr[7:0]); // Rs << 8 | zext imm8.
      exPc      <= pcIn;
   end

endmodule

/* regFile.sv */
`timescale 1ns/1ps
`include "wiscCfg.svh"

module regFile (
   input  logic                clk,
   input  logic                rstN,
   input  logic [`WISC_RW-1:0] rdAddr1,
   input  logic [`WISC_RW-1:0] rdAddr2,
   output wiscPkg::dataT       rdData1,
   output wiscPkg::dataT       rdData2,
   input  logic                wrEn,
   input  logic [`WISC_RW-1:0] wrAddr,
   input  wiscPkg::dataT       wrData
);

   import wiscPkg::*;

   dataT regs [`WISC_NREG]; // Architectural registers.

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < `WISC_NREG; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   // Write-through, a read of the register being written sees the new value.
   assign rdData1 = (wrEn && (wrAddr == rdAddr1)) ? wrData : regs[rdAddr1];
   assign rdData2 = (wrEn && (wrAddr == rdAddr2)) ? wrData : regs[rdAddr2];

endmodule

/* writeback.sv */
`timescale 1ns/1ps
`include "wiscCfg.svh"

module writeback (
   input  logic                clk,
   input  logic                rstN,
   input  logic                exValid,
   input  logic                exWrEn,
   input  logic [`WISC_RW-1:0] exDst,
   input  wiscPkg::dataT       xcomp,
   input  wiscPkg::dataT       newPc,
   output logic                wrEn,
   output logic [`WISC_RW-1:0] wrAddr,
   output wiscPkg::dataT       wrData,
   output logic                resValid,
   output wiscPkg::dataT       resData,
   output logic [`WISC_RW-1:0] resDst,
   output logic                resWr,
   output wiscPkg::dataT       resPc
);

   // Register file writes at the same edge that captures the result.
   assign wrEn   = exValid & exWrEn; // Bubbles never write.
   assign wrAddr = exDst;
   assign wrData = xcomp;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         resValid <= 1'b0;
         resWr    <= 1'b0;
      end else begin
         resValid <= exValid;
         resWr    <= wrEn;
      end
   end

   always_ff @(posedge clk) begin
      resData <= xcomp;
      resDst  <= exDst;
      resPc   <= newPc;
   end

   // Decode requests a write only for a real instruction.
   assert property (@(posedge clk) disable iff (!rstN) exWrEn |-> exValid)
      else $error("write enable from decode on a bubble");

endmodule

/* exTop.sv */
`timescale 1ns/1ps
`include "wiscCfg.svh"

module exTop (
   input  logic                clk,
   input  logic                rstN,
   input  wiscPkg::dataT       instr,
   input  wiscPkg::dataT       pcIn,
   input  logic                instrValid,
   output logic                resValid,
   output wiscPkg::dataT       resData,
   output logic [`WISC_RW-1:0] resDst,
   output logic                resWr,
   output wiscPkg::dataT       resPc
);

   import wiscPkg::*;

   // Register file ports.
   logic [`WISC_RW-1:0] rdAddr1, rdAddr2, wrAddr;
   dataT                rdData1, rdData2, wrData;
   logic                wrEn;

   // Decode/execute boundary.
   logic                exValid, exInvA, exInvB, exCin, exSign;
   logic                exImmSrc, exAluJump, exWrEn;
   opcodeT              exOpcode;
   aluOpT               exOper;
   bSrcT                exBSrc;
   brTypeT              exBrType;
   logic [`WISC_RW-1:0] exDst;
   dataT                exA, exRegData, exInst4, exInst7, exInst10, exSlbi, exPc;

   // Execute results.
   dataT                xcomp, newPc;

   decode dec (
      .clk        (clk),
      .rstN       (rstN),
      .instr      (instr),
      .pcIn       (pcIn),
      .instrValid (instrValid),
      .rdAddr1    (rdAddr1),
      .rdAddr2    (rdAddr2),
      .rdData1    (rdData1),
      .rdData2    (rdData2),
      .exValid    (exValid),
      .exOpcode   (exOpcode),
      .exOper     (exOper),
      .exBSrc     (exBSrc),
      .exInvA     (exInvA),
      .exInvB     (exInvB),
      .exCin      (exCin),
      .exSign     (exSign),
      .exImmSrc   (exImmSrc),
      .exAluJump  (exAluJump),
      .exBrType   (exBrType),
      .exWrEn     (exWrEn),
      .exDst      (exDst),
      .exA        (exA),
      .exRegData  (exRegData),
      .exInst4    (exInst4),
      .exInst7    (exInst7),
      .exInst10   (exInst10),
      .exSlbi     (exSlbi),
      .exPc       (exPc)
   );

   regFile rf (
      .clk     (clk),
      .rstN    (rstN),
      .rdAddr1 (rdAddr1),
      .rdAddr2 (rdAddr2),
      .rdData1 (rdData1),
      .rdData2 (rdData2),
      .wrEn    (wrEn),
      .wrAddr  (wrAddr),
      .wrData  (wrData)
   );

   execute ex (
      .opcode  (exOpcode),
      .pc      (exPc),
      .oper    (exOper),
      .a       (exA),
      .regData (exRegData),
      .inst4   (exInst4),
      .inst7   (exInst7),
      .inst10  (exInst10),
      .slbi    (exSlbi),
      .bSrc    (exBSrc),
      .invA    (exInvA),
      .invB    (exInvB),
      .cin     (exCin),
      .sign    (exSign),
      .immSrc  (exImmSrc),
      .aluJump (exAluJump),
      .brType  (exBrType),
      .xcomp   (xcomp),
      .newPc   (newPc),
      .bInput  ()          // Observation point only.
   );

   writeback wb (
      .clk      (clk),
      .rstN     (rstN),
      .exValid  (exValid),
      .exWrEn   (exWrEn),
      .exDst    (exDst),
      .xcomp    (xcomp),
      .newPc    (newPc),
      .wrEn     (wrEn),
      .wrAddr   (wrAddr),
      .wrData   (wrData),
      .resValid (resValid),
      .resData  (resData),
      .resDst   (resDst),
      .resWr    (resWr),
      .resPc    (resPc)
   );

endmodule

/* tb_exTop.sv */
`timescale 1ns/1ps
`include "wiscCfg.svh"

module tb_exTop;

   import wiscPkg::*;

   logic                clk = 1'b0;
   logic                rstN;
   dataT                instr;
   dataT                pcIn;
   logic                instrValid;
   logic                resValid;
   dataT                resData;
   logic [`WISC_RW-1:0] resDst;
   logic                resWr;
   dataT                resPc;

   // Stimulus table, one entry per row.
   string               rowName[$];
   logic                rowValid[$];  // Low for an idle cycle.
   dataT                rowInstr[$];
   dataT                rowPc[$];
   dataT                rowData[$];   // Expected resData.
   logic [`WISC_RW-1:0] rowDst[$];    // Expected resDst.
   logic                rowWr[$];     // Expected resWr.
   dataT                rowPcExp[$];  // Expected resPc.

   int   pending[$];       // Rows still in flight, oldest first.
   int   seed;
   int   expCount    = 0;  // Rows that must produce a result.
   int   passCount   = 0;
   int   failCount   = 0;
   int   otherErrors = 0;
   int   cycles      = 0;
   int   maxCycles   = 1000;
   dataT pcNext      = 16'h0020; // PC handed to ALU rows.

   exTop u_exTop (
      .clk        (clk),
      .rstN       (rstN),
      .instr      (instr),
      .pcIn       (pcIn),
      .instrValid (instrValid),
      .resValid   (resValid),
      .resData    (resData),
      .resDst     (resDst),
      .resWr      (resWr),
      .resPc      (resPc)
   );

   always #5 clk = ~clk; // 10 ns period.

   ////////////////////////////////////////
   // Instruction encoding.
   ////////////////////////////////////////
   function automatic dataT rWord(opcodeT op, int rs, int rt, int rd, int fn);
      return {op, rs[2:0], rt[2:0], rd[2:0], fn[1:0]};
   endfunction

   function automatic dataT iWord(opcodeT op, int rs, int rd, int imm);
      return {op, rs[2:0], rd[2:0], imm[4:0]};
   endfunction

   function automatic dataT bWord(opcodeT op, int rs, int imm);
      return {op, rs[2:0], imm[7:0]}; // lbi, slbi, branches, jr.
   endfunction

   ////////////////////////////////////////
   // Table rows.
   ////////////////////////////////////////
   task automatic aluRow(string name, dataT w, dataT exp, int dst);
      rowName.push_back(name);
      rowValid.push_back(1'b1);
      rowInstr.push_back(w);
      rowPc.push_back(pcNext);
      rowData.push_back(exp);
      rowDst.push_back(dst[`WISC_RW-1:0]);
      rowWr.push_back(1'b1);
      rowPcExp.push_back(pcNext); // Falls through.
      pcNext   = pcNext + 16'd2;
      expCount = expCount + 1;
   endtask

   task automatic branchRow(string name, dataT w, dataT pc, dataT expPc);
      rowName.push_back(name);
      rowValid.push_back(1'b1);
      rowInstr.push_back(w);
      rowPc.push_back(pc);
      rowData.push_back('0);      // Not checked, nothing written.
      rowDst.push_back('0);
      rowWr.push_back(1'b0);
      rowPcExp.push_back(expPc);
      expCount = expCount + 1;
   endtask

   task automatic bubbleRow(string name);
      rowName.push_back(name);
      rowValid.push_back(1'b0);
      rowInstr.push_back('0);
      rowPc.push_back(pcNext);
      rowData.push_back('0);
      rowDst.push_back('0);
      rowWr.push_back(1'b0);
      rowPcExp.push_back('0);
   endtask

   // Compare the result ports against one table row.
   task automatic checkResult(int idx);
      logic bad;
      bad = 1'b0;
      if (resPc !== rowPcExp[idx]) begin
         $display("error %s: resPc expected %h actual %h", rowName[idx], rowPcExp[idx], resPc);
         bad = 1'b1;
      end
      if (resWr !== rowWr[idx]) begin
         $display("error %s: resWr expected %b actual %b", rowName[idx], rowWr[idx], resWr);
         bad = 1'b1;
      end
      if (rowWr[idx] && (resData !== rowData[idx])) begin
         $display("error %s: resData expected %h actual %h", rowName[idx], rowData[idx],
                  resData);
         bad = 1'b1;
      end
      if (rowWr[idx] && (resDst !== rowDst[idx])) begin
         $display("error %s: resDst expected %0d actual %0d", rowName[idx], rowDst[idx], resDst);
         bad = 1'b1;
      end
      if (bad) begin
         failCount = failCount + 1;
      end else begin
         passCount = passCount + 1;
         $display("ok    %s", rowName[idx]);
      end
   endtask

   // Results are sampled mid-cycle, well away from the edge.
   always @(negedge clk) begin
      if (rstN === 1'b1 && $isunknown(resValid)) begin
         $display("resValid is unknown after reset");
         otherErrors = otherErrors + 1;
      end
      if (resValid === 1'b1) begin
         if (pending.size() == 0) begin
            $display("unexpected result: resValid high with no instruction in flight, resPc %h",
                     resPc);
            otherErrors = otherErrors + 1;
         end else begin
            checkResult(pending.pop_front());
         end
      end
   end

   // Run limit.
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > maxCycles) begin
         $display("timeout after %0d cycles, %0d results never arrived", cycles, pending.size());
         $display("TEST FAILED");
         $finish;
      end
   end

   initial begin
      int       rsI;
      int       rdI;
      int       imm8I;
      int       imm5I;
      int       rnd;
      logic [7:0] imm8;
      logic [4:0] imm5;
      dataT     val;
      dataT     res;

      rstN       = 1'b0;
      instr      = '0;
      pcIn       = '0;
      instrValid = 1'b0;
      seed       = 34429;

      ////////////////////////////////////////
      // Directed rows.
      ////////////////////////////////////////
      bubbleRow("idle after reset");
      bubbleRow("idle after reset 2");
      aluRow("lbi r1", bWord(opLbi, 1, 'h25), 16'h0025, 1);
      aluRow("lbi r2 negative", bWord(opLbi, 2, 'hF3), 16'hFFF3, 2);
      aluRow("add", rWord(opAlu, 1, 2, 3, 0), 16'h0018, 3);  // Both operands bypassed.
      aluRow("sub", rWord(opAlu, 1, 2, 4, 1), 16'hFFCE, 4);  // Rt - Rs.
      aluRow("xor", rWord(opAlu, 1, 2, 5, 2), 16'hFFD6, 5);
      aluRow("andn", rWord(opAlu, 2, 1, 6, 3), 16'hFFD2, 6);
      aluRow("addi", iWord(opAddi, 1, 7, 'h1D), 16'h0022, 7); // Plus -3.
      aluRow("subi", iWord(opSubi, 1, 7, 'h05), 16'hFFE0, 7); // 5 - 37.
      bubbleRow("idle mid stream");
      aluRow("xori", iWord(opXori, 1, 3, 'h1F), 16'h003A, 3);
      aluRow("andni", iWord(opAndni, 2, 3, 'h10), 16'hFFE3, 3);
      aluRow("lbi r4", bWord(opLbi, 4, 'h69), 16'h0069, 4);
      aluRow("slbi bypass", bWord(opSlbi, 4, 'h81), 16'h6981, 4);
      aluRow("roli", iWord(opRoli, 4, 5, 4), 16'h9816, 5);
      aluRow("slli", iWord(opSlli, 4, 5, 3), 16'h4C08, 5);
      aluRow("rori", iWord(opRori, 4, 5, 8), 16'h8169, 5);
      aluRow("srli", iWord(opSrli, 4, 5, 5), 16'h034C, 5);
      aluRow("lbi r6 count", bWord(opLbi, 6, 'h0C), 16'h000C, 6);
      aluRow("rol", rWord(opShift, 4, 6, 7, 0), 16'h1698, 7);
      aluRow("sll", rWord(opShift, 4, 6, 7, 1), 16'h1000, 7);
      aluRow("ror", rWord(opShift, 4, 6, 7, 2), 16'h9816, 7);
      aluRow("srl", rWord(opShift, 4, 6, 7, 3), 16'h0006, 7);
      aluRow("add self", rWord(opAlu, 4, 4, 4, 0), 16'hD302, 4);
      aluRow("add dependent", rWord(opAlu, 4, 6, 3, 0), 16'hD30E, 3);
      aluRow("lbi r1 7f", bWord(opLbi, 1, 'h7F), 16'h007F, 1);
      aluRow("slbi r1 max", bWord(opSlbi, 1, 'hFF), 16'h7FFF, 1);
      aluRow("lbi r2 -128", bWord(opLbi, 2, 'h80), 16'hFF80, 2);
      aluRow("seq equal", rWord(opSeq, 1, 1, 3, 0), 16'h0001, 3);
      aluRow("seq differ", rWord(opSeq, 1, 2, 3, 0), 16'h0000, 3);
      aluRow("slt overflow", rWord(opSlt, 2, 1, 3, 0), 16'h0001, 3); // -128 < 32767.
      aluRow("slt false", rWord(opSlt, 1, 2, 3, 0), 16'h0000, 3);
      aluRow("sle equal", rWord(opSle, 1, 1, 3, 0), 16'h0001, 3);
      aluRow("sle false", rWord(opSle, 1, 2, 3, 0), 16'h0000, 3);
      aluRow("sle true", rWord(opSle, 2, 1, 3, 0), 16'h0001, 3);
      aluRow("sco carry", rWord(opSco, 1, 2, 3, 0), 16'h0001, 3);
      aluRow("sco no carry", rWord(opSco, 1, 1, 3, 0), 16'h0000, 3);
      // r1 7FFF, r2 FF80, r3 0, r4 D302, r5 034C.
      branchRow("beqz taken", bWord(opBeqz, 3, 'h10), 16'h0100, 16'h0110);
      branchRow("beqz not taken", bWord(opBeqz, 1, 'h10), 16'h0102, 16'h0102);
      branchRow("bnez taken back", bWord(opBnez, 1, 'hF0), 16'h0104, 16'h00F4);
      branchRow("bnez not taken", bWord(opBnez, 3, 'h10), 16'h0106, 16'h0106);
      branchRow("bltz taken", bWord(opBltz, 2, 'h08), 16'h0108, 16'h0110);
      branchRow("bltz not taken", bWord(opBltz, 1, 'h08), 16'h010A, 16'h010A);
      branchRow("bgez taken", bWord(opBgez, 1, 'h20), 16'h010C, 16'h012C);
      branchRow("bgez zero", bWord(opBgez, 3, 'h20), 16'h010E, 16'h012E);
      branchRow("bgez not taken", bWord(opBgez, 4, 'h20), 16'h0110, 16'h0110);
      branchRow("jr forward", bWord(opJr, 5, 'h04), 16'h0112, 16'h0350);
      branchRow("jr back", bWord(opJr, 5, 'hFC), 16'h0114, 16'h0348);
      bubbleRow("idle after jr");

      // Random immediates on a freshly loaded register.
      for (int i = 0; i < 6; i++) begin
         rsI   = $random(seed) & 7;
         rdI   = $random(seed) & 7;
         imm8I = $random(seed);
         imm5I = $random(seed);
         rnd   = $random(seed);
         imm8  = imm8I[7:0];
         imm5  = imm5I[4:0];
         val   = {{8{imm8[7]}}, imm8};
         aluRow($sformatf("rand lbi r%0d", rsI), bWord(opLbi, rsI, imm8I), val, rsI);
         if (rnd[0]) begin
            res = val ^ {11'b0, imm5};              // Zero-extended immediate.
            aluRow($sformatf("rand xori r%0d", rdI), iWord(opXori, rsI, rdI, imm5I), res, rdI);
         end else begin
            res = val + {{11{imm5[4]}}, imm5};      // Sign-extended immediate.
            aluRow($sformatf("rand addi r%0d", rdI), iWord(opAddi, rsI, rdI, imm5I), res, rdI);
         end
      end

      maxCycles = rowName.size() + 4 + 20;

      ////////////////////////////////////////
      // Reset, then one row per cycle.
      ////////////////////////////////////////
      repeat (4) @(posedge clk);
      rstN <= 1'b1;
      for (int i = 0; i < rowName.size(); i++) begin
         @(posedge clk);
         instr      <= rowInstr[i];
         pcIn       <= rowPc[i];
         instrValid <= rowValid[i];
         if (rowValid[i]) begin
            pending.push_back(i);
         end
      end
      @(posedge clk);
      instrValid <= 1'b0;
      instr      <= '0;

      while (pending.size() != 0) begin
         @(posedge clk);
      end
      repeat (3) @(posedge clk); // Catch stray results.

      $display("%0d checked, %0d passed, %0d failed, %0d other errors",
               passCount + failCount, passCount, failCount, otherErrors);
      if (failCount == 0 && otherErrors == 0 && passCount == expCount) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* tb.f */
+incdir+.
wiscPkg.sv
cla_16b.sv
alu.sv
execute.sv
decode.sv
regFile.sv
writeback.sv
exTop.sv
tb_exTop.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_exTop
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard *.sv *.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
